/* hw/correlator_pkg.sv */
`default_nettype none

package correlator_pkg;

   // --------------------------------------------------
   // Array geometry
   // --------------------------------------------------

   // Antennas feeding every unit
   localparam int NUM_ANT    = 12;
   // Baselines handled per unit, one per clock
   localparam int NUM_PAIRS  = 12;
   localparam int ANT_IDX_W  = 4;
   localparam int PAIR_IDX_W = 4;
   // Units joined by the block
   localparam int NUM_UNITS  = 2;

   // --------------------------------------------------
   // Bus address map
   // --------------------------------------------------

   // Bit 5 picks the unit
   // Bits 4..1 give the pair index
   // Bit 0 selects cos (0) or sin (1)
   localparam int BUS_ADR_W  = 6;

   // One baseline, antenna indices into re/im
   typedef struct packed {
      logic [ANT_IDX_W-1:0] ant_a;
      logic [ANT_IDX_W-1:0] ant_b;
   } pair_t;

   // Pair 0 sits in the low byte
   typedef pair_t [NUM_PAIRS-1:0] pair_table_t;

   // --------------------------------------------------
   // Per-unit baseline tables
   // --------------------------------------------------

   // Antennas 6..11 against antennas 0 and 1
   localparam pair_table_t PAIRS_UNIT0 = 96'hb1a1_9181_7161_b0a0_9080_7060;
   // Antennas 6..11 against antennas 2 and 3
   localparam pair_table_t PAIRS_UNIT1 = 96'hb3a3_9383_7363_b2a2_9282_7262;

endpackage

`default_nettype wire

/* hw/pair_op_if.sv */
`default_nettype none

interface pair_op_if;
   import correlator_pkg::*;

   // High for each cycle an operation is presented
   logic                  valid;
   // Accumulator slot of this baseline
   logic [PAIR_IDX_W-1:0] pair_idx;
   // Sign bits of both antennas of the pair
   logic                  a_re;
   logic                  a_im;
   logic                  b_re;
   logic                  b_im;

   // Decode side, no back-pressure
   modport source (output valid, pair_idx, a_re, a_im, b_re, b_im);

   // Execute side, consumes every valid cycle
   modport sink (input valid, pair_idx, a_re, a_im, b_re, b_im);

endinterface

`default_nettype wire

/* hw/pair_decode.sv */
`default_nettype none

module pair_decode #(
   parameter correlator_pkg::pair_table_t PAIRS = correlator_pkg::PAIRS_UNIT0
) (
   input  logic                               clk_x,
   input  logic                               rst_n_i,
   input  logic                               en_i,
   input  logic [correlator_pkg::NUM_ANT-1:0] re_i,
   input  logic [correlator_pkg::NUM_ANT-1:0] im_i,
   pair_op_if.source                          op_o
);
   import correlator_pkg::*;

   // Captured sample, held while the pairs issue
   logic [NUM_ANT-1:0]    samp_re;
   logic [NUM_ANT-1:0]    samp_im;
   // Sequencer state
   logic [PAIR_IDX_W-1:0] pair_cnt;
   logic                  busy;
   logic                  start;
   logic                  last_pair;
   pair_t                 cur_pair;

   // New sample only accepted when idle
   assign start     = en_i && !busy;
   assign last_pair = (pair_cnt == PAIR_IDX_W'(NUM_PAIRS - 1));

   // --------------------------------------------------
   // Pair sequencer
   // --------------------------------------------------
   always_ff @(posedge clk_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy     <= 1'b0;
         pair_cnt <= '0;
      end else if (start) begin
         busy     <= 1'b1;
         pair_cnt <= '0;
      end else if (busy) begin
         // Pair 11 consumed on this edge, back to idle
         if (last_pair) begin
            busy     <= 1'b0;
            pair_cnt <= '0;
         end else begin
            pair_cnt <= pair_cnt + 1'b1;
         end
      end
   end

   // Sample capture
   always_ff @(posedge clk_x) begin
      if (start) begin
         samp_re <= re_i;
         samp_im <= im_i;
      end
   end

   // Table lookup for the pair on issue
   assign cur_pair = PAIRS[pair_cnt];

   assign op_o.valid    = busy;
   assign op_o.pair_idx = pair_cnt;
   assign op_o.a_re     = samp_re[cur_pair.ant_a];
   assign op_o.a_im     = samp_im[cur_pair.ant_a];
   assign op_o.b_re     = samp_re[cur_pair.ant_b];
   assign op_o.b_im     = samp_im[cur_pair.ant_b];

endmodule

`default_nettype wire

/* hw/correlate_execute.sv */
`default_nettype none

module correlate_execute #(
   parameter int ACCUM = 32
) (
   input  logic                                  clk_x,
   input  logic                                  rst_n_i,
   input  logic                                  sw_i,
   pair_op_if.sink                               op_i,
   input  logic [correlator_pkg::PAIR_IDX_W-1:0] rd_pair_i,
   input  logic                                  rd_sin_i,
   output logic [ACCUM-1:0]                      rd_data_o,
   output logic                                  overflow_cos_o,
   output logic                                  overflow_sin_o
);
   import correlator_pkg::*;

   // Two banks of cos and sin accumulators
   logic [ACCUM-1:0]           cos_acc [2][NUM_PAIRS];
   logic [ACCUM-1:0]           sin_acc [2][NUM_PAIRS];
   // Stale entry reads as zero until first touched
   logic [1:0][NUM_PAIRS-1:0]  stale;
   logic                       act_bank;
   logic                       rd_bank;

   logic [1:0]                 cos_inc;
   logic [1:0]                 sin_inc;
   logic                       op_stale;
   logic [ACCUM-1:0]           cos_base;
   logic [ACCUM-1:0]           sin_base;
   // One extra bit catches the wrap
   logic [ACCUM:0]             cos_sum;
   logic [ACCUM:0]             sin_sum;
   logic                       rd_stale;
   logic [ACCUM-1:0]           rd_word;

   // --------------------------------------------------
   // Sign-product increments
   // --------------------------------------------------

   // Real part, both components agree
   assign cos_inc = {1'b0, op_i.a_re == op_i.b_re} + {1'b0, op_i.a_im == op_i.b_im};
   // Imaginary part, conjugate product signs
   assign sin_inc = {1'b0, op_i.a_im == op_i.b_re} + {1'b0, op_i.a_re != op_i.b_im};

   // First touch after a switch starts from zero
   assign op_stale = stale[act_bank][op_i.pair_idx];
   assign cos_base = op_stale ? '0 : cos_acc[act_bank][op_i.pair_idx];
   assign sin_base = op_stale ? '0 : sin_acc[act_bank][op_i.pair_idx];

   assign cos_sum = {1'b0, cos_base} + (ACCUM + 1)'(cos_inc);
   assign sin_sum = {1'b0, sin_base} + (ACCUM + 1)'(sin_inc);

   // --------------------------------------------------
   // Bank control and sticky flags
   // --------------------------------------------------
   always_ff @(posedge clk_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         act_bank       <= 1'b0;
         // Both banks read as zero out of reset
         stale          <= '1;
         overflow_cos_o <= 1'b0;
         overflow_sin_o <= 1'b0;
      end else begin
         if (op_i.valid) begin
            stale[act_bank][op_i.pair_idx] <= 1'b0;
            if (cos_sum[ACCUM]) begin
               overflow_cos_o <= 1'b1;
            end
            if (sin_sum[ACCUM]) begin
               overflow_sin_o <= 1'b1;
            end
         end
         // Swap wins over a flag set in the same cycle
         if (sw_i) begin
            act_bank        <= !act_bank;
            stale[!act_bank] <= '1;
            overflow_cos_o  <= 1'b0;
            overflow_sin_o  <= 1'b0;
         end
      end
   end

   // Accumulator storage, written into the active bank
   always_ff @(posedge clk_x) begin
      if (op_i.valid) begin
         cos_acc[act_bank][op_i.pair_idx] <= cos_sum[ACCUM-1:0];
         sin_acc[act_bank][op_i.pair_idx] <= sin_sum[ACCUM-1:0];
      end
   end

   // --------------------------------------------------
   // Read port
   // --------------------------------------------------

   // Bus only sees the sealed bank
   assign rd_bank   = !act_bank;
   assign rd_stale  = stale[rd_bank][rd_pair_i];
   assign rd_word   = rd_sin_i ? sin_acc[rd_bank][rd_pair_i] : cos_acc[rd_bank][rd_pair_i];
   assign rd_data_o = rd_stale ? '0 : rd_word;

endmodule

`default_nettype wire

/* hw/visibility_result.sv */
`default_nettype none

module visibility_result #(
   parameter int ACCUM = 32
) (
   input  logic                                  clk_x,
   input  logic                                  rst_n_i,
   input  logic                                  cyc_i,
   input  logic                                  stb_i,
   input  logic [correlator_pkg::BUS_ADR_W-2:0]  adr_i,
   output logic                                  ack_o,
   output logic [ACCUM-1:0]                      dat_o,
   output logic [correlator_pkg::PAIR_IDX_W-1:0] rd_pair_o,
   output logic                                  rd_sin_o,
   input  logic [ACCUM-1:0]                      rd_data_i
);
   import correlator_pkg::*;

   logic req;
   logic in_range;

   // Address split into pair and component
   assign rd_pair_o = adr_i[PAIR_IDX_W:1];
   assign rd_sin_o  = adr_i[0];
   // Slots 12..15 are unpopulated
   assign in_range  = (rd_pair_o < PAIR_IDX_W'(NUM_PAIRS));

   // New request, not the cycle already acknowledged
   assign req = cyc_i && stb_i && !ack_o;

   // One-cycle acknowledge
   always_ff @(posedge clk_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= req;
      end
   end

   // Visibility latched alongside the acknowledge
   always_ff @(posedge clk_x) begin
      if (req) begin
         dat_o <= in_range ? rd_data_i : '0;
      end
   end

endmodule

`default_nettype wire

/* hw/correlator.sv */
`default_nettype none

module correlator #(
   parameter int                          ACCUM = 32,
   parameter correlator_pkg::pair_table_t PAIRS = correlator_pkg::PAIRS_UNIT0
) (
   input  logic                                 clk_x,
   input  logic                                 rst_n_i,
   // Read bus
   input  logic                                 cyc_i,
   input  logic                                 stb_i,
   input  logic [correlator_pkg::BUS_ADR_W-2:0] adr_i,
   output logic                                 ack_o,
   output logic [ACCUM-1:0]                     dat_o,
   // Antenna side
   input  logic                                 sw_i,
   input  logic                                 en_i,
   input  logic [correlator_pkg::NUM_ANT-1:0]   re_i,
   input  logic [correlator_pkg::NUM_ANT-1:0]   im_i,
   // Sticky wrap flags
   output logic                                 overflow_cos_o,
   output logic                                 overflow_sin_o
);
   import correlator_pkg::*;

   // Decode to execute, one pair per clock
   pair_op_if op_if ();

   // Read path, bus slave to sealed bank
   logic [PAIR_IDX_W-1:0] rd_pair;
   logic                  rd_sin;
   logic [ACCUM-1:0]      rd_data;

   pair_decode #(
      .PAIRS (PAIRS)
   ) u_decode (
      .clk_x   (clk_x),
      .rst_n_i (rst_n_i),
      .en_i    (en_i),
      .re_i    (re_i),
      .im_i    (im_i),
      .op_o    (op_if.source)
   );

   correlate_execute #(
      .ACCUM (ACCUM)
   ) u_execute (
      .clk_x          (clk_x),
      .rst_n_i        (rst_n_i),
      .sw_i           (sw_i),
      .op_i           (op_if.sink),
      .rd_pair_i      (rd_pair),
      .rd_sin_i       (rd_sin),
      .rd_data_o      (rd_data),
      .overflow_cos_o (overflow_cos_o),
      .overflow_sin_o (overflow_sin_o)
   );

   visibility_result #(
      .ACCUM (ACCUM)
   ) u_result (
      .clk_x     (clk_x),
      .rst_n_i   (rst_n_i),
      .cyc_i     (cyc_i),
      .stb_i     (stb_i),
      .adr_i     (adr_i),
      .ack_o     (ack_o),
      .dat_o     (dat_o),
      .rd_pair_o (rd_pair),
      .rd_sin_o  (rd_sin),
      .rd_data_i (rd_data)
   );

endmodule

`default_nettype wire

/* hw/correlator_block.sv */
`default_nettype none

module correlator_block #(
   parameter int ACCUM = 32
) (
   input  logic                                 clk_x,
   input  logic                                 rst_n_i,

   // Wishbone-like read bus, writes acknowledged and dropped
   input  logic                                 cyc_i,
   input  logic                                 stb_i,
   input  logic                                 we_i,
   input  logic [correlator_pkg::BUS_ADR_W-1:0] adr_i,
   input  logic [ACCUM-1:0]                     dat_i,
   output logic                                 ack_o,
   output logic [ACCUM-1:0]                     dat_o,

   // Antenna samples
   input  logic                                 sw_i,
   input  logic                                 en_i,
   input  logic [correlator_pkg::NUM_ANT-1:0]   re_i,
   input  logic [correlator_pkg::NUM_ANT-1:0]   im_i,

   output logic                                 overflow_cos_o,
   output logic                                 overflow_sin_o
);
   import correlator_pkg::*;

   // Per-unit returns
   logic [NUM_UNITS-1:0] unit_ack;
   logic [NUM_UNITS-1:0] unit_oc;
   logic [NUM_UNITS-1:0] unit_os;
   logic [ACCUM-1:0]     unit_dat [NUM_UNITS];
   logic                 unit_idx;

   // Top address bit picks the unit
   assign unit_idx = adr_i[BUS_ADR_W-1];

   // --------------------------------------------------
   // Correlator units
   // --------------------------------------------------
   for (genvar u = 0; u < NUM_UNITS; u++) begin : g_unit
      // Each unit gets its own baseline set
      localparam pair_table_t UNIT_PAIRS = (u == 0) ? PAIRS_UNIT0 : PAIRS_UNIT1;

      logic unit_sel;

      assign unit_sel = (unit_idx == 1'(u));

      correlator #(
         .ACCUM (ACCUM),
         .PAIRS (UNIT_PAIRS)
      ) u_correlator (
         .clk_x          (clk_x),
         .rst_n_i        (rst_n_i),
         .cyc_i          (cyc_i),
         // Strobe only reaches the addressed unit
         .stb_i          (stb_i && unit_sel),
         .adr_i          (adr_i[BUS_ADR_W-2:0]),
         .ack_o          (unit_ack[u]),
         .dat_o          (unit_dat[u]),
         .sw_i           (sw_i),
         .en_i           (en_i),
         .re_i           (re_i),
         .im_i           (im_i),
         .overflow_cos_o (unit_oc[u]),
         .overflow_sin_o (unit_os[u])
      );
   end

   // --------------------------------------------------
   // Read return and flags
   // --------------------------------------------------

   // Address held by the master until ack
   assign ack_o = unit_ack[unit_idx];
   assign dat_o = unit_dat[unit_idx];

   // Any unit wrapping raises the block flag
   assign overflow_cos_o = |unit_oc;
   assign overflow_sin_o = |unit_os;

endmodule

`default_nettype wire

/* testbench/tb_correlator_block.sv */
`default_nettype none

module tb_correlator_block;
   timeunit 1ns;
   timeprecision 100ps;
   import correlator_pkg::*;

   localparam int ACCUM   = 10;
   localparam int ACC_MOD = 1 << ACCUM;
   // About twice the cycles all tests need
   localparam int TIMEOUT = 20000;

   logic                 clk_x;
   logic                 rst_n_i;
   logic                 cyc_i;
   logic                 stb_i;
   logic                 we_i;
   logic [BUS_ADR_W-1:0] adr_i;
   logic [ACCUM-1:0]     dat_i;
   logic                 ack_o;
   logic [ACCUM-1:0]     dat_o;
   logic                 sw_i;
   logic                 en_i;
   logic [NUM_ANT-1:0]   re_i;
   logic [NUM_ANT-1:0]   im_i;
   logic                 overflow_cos_o;
   logic                 overflow_sin_o;

   // Reference banks indexed by unit, bank and pair
   int unsigned        mdl_cos [NUM_UNITS][2][NUM_PAIRS] = '{default: 0};
   int unsigned        mdl_sin [NUM_UNITS][2][NUM_PAIRS] = '{default: 0};
   bit                 mdl_stale [NUM_UNITS][2][NUM_PAIRS] = '{default: 1'b1};
   bit                 mdl_act = 1'b0;
   bit [NUM_UNITS-1:0] mdl_oc = '0;
   bit [NUM_UNITS-1:0] mdl_os = '0;
   int                 cycle_cnt = 0;

   correlator_block #(.ACCUM(ACCUM)) dut_i (.*);

   initial begin
      clk_x = 1'b0;
      forever #4 clk_x = ~clk_x;
   end

   always @(posedge clk_x) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT) begin
         fail_run("Timeout: the tests did not finish within the cycle limit");
      end
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "Simulation stopped");
   endtask

   // --------------------------------------------------
   // Compare tasks and reference model
   // --------------------------------------------------
   task automatic compare_vis(input logic [ACCUM-1:0] got, input logic [ACCUM-1:0] exp,
                              input string what);
      if (got !== exp) begin
         fail_run($sformatf("Error at %0t ns: %s read %0d, expected %0d",
                            $time, what, got, exp));
      end
   endtask

   task automatic compare_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   // Stale entries of the sealed bank read zero
   function automatic logic [ACCUM-1:0] model_vis(input int u, input int p, input bit s);
      bit b;
      b = !mdl_act;
      return mdl_stale[u][b][p] ? '0 : ACCUM'(s ? mdl_sin[u][b][p] : mdl_cos[u][b][p]);
   endfunction

   // Agreement counts into the active bank
   task automatic model_update(input logic [NUM_ANT-1:0] re, input logic [NUM_ANT-1:0] im);
      pair_table_t tbl;
      pair_t       pr;
      int unsigned c_new;
      int unsigned s_new;
      for (int u = 0; u < NUM_UNITS; u++) begin
         tbl = (u == 0) ? PAIRS_UNIT0 : PAIRS_UNIT1;
         for (int p = 0; p < NUM_PAIRS; p++) begin
            pr = tbl[p];
            c_new = 32'(re[pr.ant_a] == re[pr.ant_b]) + 32'(im[pr.ant_a] == im[pr.ant_b]);
            s_new = 32'(im[pr.ant_a] == re[pr.ant_b]) + 32'(re[pr.ant_a] != im[pr.ant_b]);
            // First touch after a swap starts from zero
            if (!mdl_stale[u][mdl_act][p]) begin
               c_new += mdl_cos[u][mdl_act][p];
               s_new += mdl_sin[u][mdl_act][p];
            end
            mdl_oc[u] |= (c_new >= ACC_MOD);
            mdl_os[u] |= (s_new >= ACC_MOD);
            mdl_cos[u][mdl_act][p] = c_new % ACC_MOD;
            mdl_sin[u][mdl_act][p] = s_new % ACC_MOD;
            mdl_stale[u][mdl_act][p] = 1'b0;
         end
      end
   endtask

   // --------------------------------------------------
   // Stimulus
   // --------------------------------------------------

   // Samples spaced 16 cycles apart
   // Optional second strobe while the unit is busy
   task automatic send_sample(input logic [NUM_ANT-1:0] re, input logic [NUM_ANT-1:0] im,
                              input bit overlap);
      @(posedge clk_x);
      #1;
      en_i = 1'b1;
      re_i = re;
      im_i = im;
      @(posedge clk_x);
      #1 en_i = 1'b0;
      model_update(re, im);
      if (overlap) begin
         // Strobe lands on issue edge 5 and is dropped by the DUT
         repeat (4) @(posedge clk_x);
         #1;
         en_i = 1'b1;
         re_i = NUM_ANT'($urandom());
         im_i = NUM_ANT'($urandom());
         @(posedge clk_x);
         #1 en_i = 1'b0;
         repeat (9) @(posedge clk_x);
      end else begin
         repeat (14) @(posedge clk_x);
      end
   endtask

   task automatic send_batch(input int n);
      for (int i = 0; i < n; i++) begin
         send_sample(NUM_ANT'($urandom()), NUM_ANT'($urandom()), 1'b0);
      end
   endtask

   // Swap with the pipeline empty
   task automatic pulse_switch();
      @(posedge clk_x);
      #1 sw_i = 1'b1;
      @(posedge clk_x);
      #1 sw_i = 1'b0;
      mdl_act = !mdl_act;
      mdl_oc  = '0;
      mdl_os  = '0;
      for (int u = 0; u < NUM_UNITS; u++) begin
         for (int p = 0; p < NUM_PAIRS; p++) begin
            mdl_stale[u][mdl_act][p] = 1'b1;
         end
      end
   endtask

   // Strobe held until the ack one cycle later
   task automatic bus_cycle(input logic [BUS_ADR_W-1:0] adr, input logic we,
                            output logic [ACCUM-1:0] rdata);
      int waited;
      waited = 0;
      @(posedge clk_x);
      #1;
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = we;
      adr_i = adr;
      dat_i = ACCUM'($urandom());
      while (ack_o !== 1'b1 && waited < 8) begin
         @(posedge clk_x);
         #1;
         waited++;
      end
      if (waited != 1) begin
         fail_run($sformatf("Bus acknowledge for address %0d took %0d cycles instead of 1",
                            adr, waited));
      end
      rdata = dat_o;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
   endtask

   task automatic read_all(input string tag);
      logic [ACCUM-1:0] rd;
      for (int u = 0; u < NUM_UNITS; u++) begin
         for (int p = 0; p < NUM_PAIRS; p++) begin
            for (int s = 0; s < 2; s++) begin
               bus_cycle({1'(u), PAIR_IDX_W'(p), 1'(s)}, 1'b0, rd);
               compare_vis(rd, model_vis(u, p, s[0]),
                           $sformatf("%s unit %0d pair %0d %s", tag, u, p, s ? "sin" : "cos"));
            end
         end
      end
   endtask

   task automatic check_flags(input string tag);
      compare_flag(overflow_cos_o, |mdl_oc, {tag, " overflow_cos_o"});
      compare_flag(overflow_sin_o, |mdl_os, {tag, " overflow_sin_o"});
   endtask

   // --------------------------------------------------
   // Directed tests
   // --------------------------------------------------

   // Both banks empty out of reset
   task automatic reads_after_reset();
      check_flags("reset");
      read_all("reset");
   endtask

   task automatic bank_swaps();
      // Random batch sealed into bank 0
      send_batch(20);
      pulse_switch();
      check_flags("batch 1");
      read_all("batch 1");
      // Bank 1 sealed before bank 0 is refilled over old data
      send_batch(15);
      pulse_switch();
      read_all("batch 2");
      send_batch(15);
      pulse_switch();
      read_all("batch 3");
   endtask

   task automatic overlapped_samples();
      send_sample(NUM_ANT'($urandom()), NUM_ANT'($urandom()), 1'b1);
      send_sample(NUM_ANT'($urandom()), NUM_ANT'($urandom()), 1'b1);
      pulse_switch();
      read_all("overlap");
   endtask

   // 520 x 2 wraps a 10-bit cosine sum
   task automatic cosine_wrap();
      logic [ACCUM-1:0] rd;
      repeat (520) send_sample('0, '0, 1'b0);
      check_flags("wrap");
      pulse_switch();
      bus_cycle('0, 1'b0, rd);
      compare_vis(rd, ACCUM'(2 * 520), "wrap unit 0 pair 0 cos");
      check_flags("after swap");
      read_all("wrap");
   endtask

   // Slots 12..15 read empty and writes are dropped
   task automatic unpopulated_and_writes();
      logic [ACCUM-1:0] rd;
      for (int a = 0; a < 2 ** BUS_ADR_W; a++) begin
         if (a[BUS_ADR_W-2:1] >= NUM_PAIRS) begin
            bus_cycle(BUS_ADR_W'(a), 1'b0, rd);
            compare_vis(rd, '0, $sformatf("unpopulated address %0d", a));
         end
      end
      bus_cycle(6'h03, 1'b1, rd);
      bus_cycle(6'h21, 1'b1, rd);
      read_all("after write");
   endtask

   initial begin
      void'($urandom(32'h5841046a));
      rst_n_i = 1'b0;
      cyc_i   = 1'b0;
      stb_i   = 1'b0;
      we_i    = 1'b0;
      adr_i   = '0;
      dat_i   = '0;
      sw_i    = 1'b0;
      en_i    = 1'b0;
      re_i    = '0;
      im_i    = '0;
      repeat (16) @(posedge clk_x);
      #1 rst_n_i = 1'b1;

      reads_after_reset();
      bank_swaps();
      overlapped_samples();
      cosine_wrap();
      unpopulated_and_writes();

      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

/* correlator_block.f */
hw/correlator_pkg.sv
hw/pair_op_if.sv
hw/pair_decode.sv
hw/correlate_execute.sv
hw/visibility_result.sv
hw/correlator.sv
hw/correlator_block.sv
testbench/tb_correlator_block.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the correlator testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f correlator_block.f \
   --top-module tb_correlator_block -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
